// ==== csi2_consts.svh ====
`ifndef CSI2_CONSTS_SVH
`define CSI2_CONSTS_SVH

// Sync byte that opens every packet on each lane.
`define CSI2_SYNC_BYTE 8'hB8

// Data type codes handled by the receiver.
`define CSI2_DT_FS   6'h00
`define CSI2_DT_FE   6'h01
`define CSI2_DT_RAW8 6'h2A

// Output FIFO depth in pixel words.
`define CSI2_FIFO_DEPTH 16

// Width of the per-lane bit-slip offset.
`define CSI2_SLIP_W 3

`endif

// ==== csi2_pkg.sv ====
`include "csi2_consts.svh"

package csi2_pkg;

  // One deserialized byte from a D-PHY lane.
  typedef logic [7 : 0]  lane_byte_t;

  // Output pixel word, lane 1 in the high byte.
  typedef logic [15 : 0] px_word_t;

  // Long packet word count, in bytes.
  typedef logic [15 : 0] word_cnt_t;

  typedef logic [5 : 0]  data_type_t;

  typedef logic [`CSI2_SLIP_W - 1 : 0] slip_t;

  typedef enum logic [2 : 0]
  {
    IDLE,
    HDR2,
    PAYLOAD,
    CRC,
    DROP
  } parser_state_t;

endpackage

// ==== csi2_delay_ctrl.sv ====
`timescale 1ns/1ps

module csi2_delay_ctrl
  import csi2_pkg::*;
(
  input  logic         ref_clk_i,
  input  logic         ref_srst_i,
  input  logic [1 : 0] btn_i,
  output slip_t        slip0_o,
  output slip_t        slip1_o
);

logic [1 : 0] btn_d1;
logic [1 : 0] btn_d2;
logic [1 : 0] btn_d3;
logic [1 : 0] inc_slip;
slip_t        slip_cnt [2];

// Two synchronizer stages, then one more flop for the edge detect.
always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      btn_d1 <= '0;
      btn_d2 <= '0;
      btn_d3 <= '0;
    end
  else
    begin
      btn_d1 <= btn_i;
      btn_d2 <= btn_d1;
      btn_d3 <= btn_d2;
    end

assign inc_slip = btn_d2 & ~btn_d3;

// Each press moves its lane one bit further, wrapping after 7.
always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    slip_cnt <= '{ default: '0 };
  else
    for( int i = 0; i < 2; i++ )
      begin
        if( inc_slip[i] )
          slip_cnt[i] <= slip_cnt[i] + 1'b1;
      end

assign slip0_o = slip_cnt[0];
assign slip1_o = slip_cnt[1];

endmodule

// ==== csi2_lane_aligner.sv ====
`timescale 1ns/1ps

`include "csi2_consts.svh"

module csi2_lane_aligner
  import csi2_pkg::*;
(
  input  logic       ref_clk_i,
  input  logic       ref_srst_i,
  input  lane_byte_t raw_i,
  input  logic       raw_valid_i,
  input  slip_t      slip_i,
  input  logic       peer_hit_i,
  input  logic       pkt_end_i,
  output logic       sync_hit_o,
  output lane_byte_t byte_o,
  output logic       byte_valid_o
);

typedef enum logic
{
  HUNT,
  LOCK
} align_state_t;

align_state_t  state;
lane_byte_t    raw_prev;
logic [15 : 0] window;
lane_byte_t    aligned;

always_ff @( posedge ref_clk_i )
  if( raw_valid_i )
    raw_prev <= raw_i;

// Current word on top, previous word below; slip picks the start bit.
assign window  = { raw_i, raw_prev };
assign aligned = window[slip_i +: 8];

assign sync_hit_o = ( state == HUNT ) && raw_valid_i &&
                    ( aligned == `CSI2_SYNC_BYTE );

// Lock only when the other lane sees sync in the same cycle.
always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    state <= HUNT;
  else
    case( state )
      HUNT:
        begin
          if( sync_hit_o && peer_hit_i )
            state <= LOCK;
        end
      LOCK:
        begin
          if( pkt_end_i )
            state <= HUNT;
        end
      default:
        state <= HUNT;
    endcase

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    byte_valid_o <= 1'b0;
  else
    byte_valid_o <= ( state == LOCK ) && raw_valid_i && !pkt_end_i;

always_ff @( posedge ref_clk_i )
  if( ( state == LOCK ) && raw_valid_i )
    byte_o <= aligned;

endmodule

// ==== csi2_pkt_parser.sv ====
`timescale 1ns/1ps

`include "csi2_consts.svh"

module csi2_pkt_parser
  import csi2_pkg::*;
(
  input  logic       ref_clk_i,
  input  logic       ref_srst_i,
  input  lane_byte_t lane0_i,
  input  lane_byte_t lane1_i,
  input  logic       bytes_valid_i,
  output logic       pkt_end_o,
  output logic       wr_o,
  output px_word_t   wr_data_o,
  output logic       wr_user_o,
  output logic       wr_last_o
);

parser_state_t state;
data_type_t    dt;
lane_byte_t    wc_lo;
word_cnt_t     wc;
word_cnt_t     words_left;
logic          dt_short;
logic          fs_pending;

// First header cycle gives DI on lane 0 and the low count byte on lane 1.
always_ff @( posedge ref_clk_i )
  if( ( state == IDLE ) && bytes_valid_i )
    begin
      dt    <= data_type_t'( lane0_i[5 : 0] );
      wc_lo <= lane1_i;
    end

assign wc = { lane0_i, wc_lo };

// Data types 0x00 to 0x0F are short packets.
assign dt_short = ( dt[5 : 4] == 2'b00 );

assign pkt_end_o = bytes_valid_i &&
                   ( ( ( state == HDR2 ) && dt_short ) || ( state == CRC ) );

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      state      <= IDLE;
      words_left <= '0;
      fs_pending <= 1'b0;
    end
  else
    if( bytes_valid_i )
      case( state )
        IDLE:
          state <= HDR2;
        HDR2:
          begin
            // Lane 1 holds the ECC byte here; it is not checked.
            words_left <= wc >> 1;
            if( dt_short )
              begin
                state <= IDLE;
                if( dt == `CSI2_DT_FS )
                  fs_pending <= 1'b1;
                else if( dt == `CSI2_DT_FE )
                  fs_pending <= 1'b0;
              end
            else if( wc < 16'd2 )
              state <= CRC;
            else if( dt == `CSI2_DT_RAW8 )
              state <= PAYLOAD;
            else
              state <= DROP;
          end
        PAYLOAD:
          begin
            words_left <= words_left - 1'b1;
            fs_pending <= 1'b0;
            if( words_left == 16'd1 )
              state <= CRC;
          end
        DROP:
          begin
            words_left <= words_left - 1'b1;
            if( words_left == 16'd1 )
              state <= CRC;
          end
        CRC:
          state <= IDLE;
        default:
          state <= IDLE;
      endcase

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    wr_o <= 1'b0;
  else
    wr_o <= bytes_valid_i && ( state == PAYLOAD );

// Lane 0 goes to the low byte.
always_ff @( posedge ref_clk_i )
  if( bytes_valid_i && ( state == PAYLOAD ) )
    begin
      wr_data_o <= { lane1_i, lane0_i };
      wr_user_o <= fs_pending;
      wr_last_o <= ( words_left == 16'd1 );
    end

endmodule

// ==== csi2_px_fifo.sv ====
`timescale 1ns/1ps

`include "csi2_consts.svh"

module csi2_px_fifo
  import csi2_pkg::*;
(
  input  logic     ref_clk_i,
  input  logic     ref_srst_i,
  input  logic     wr_i,
  input  px_word_t wr_data_i,
  input  logic     wr_user_i,
  input  logic     wr_last_i,
  input  logic     video_tready_i,
  output px_word_t video_tdata_o,
  output logic     video_tvalid_o,
  output logic     video_tuser_o,
  output logic     video_tlast_o,
  output logic     overflow_o
);

localparam int DEPTH   = `CSI2_FIFO_DEPTH;
localparam int PTR_W   = $clog2( DEPTH );
localparam int CNT_W   = $clog2( DEPTH + 1 );
localparam int ENTRY_W = $bits( px_word_t ) + 2;

logic [ENTRY_W - 1 : 0] mem [DEPTH];
logic [PTR_W - 1 : 0]   wr_ptr;
logic [PTR_W - 1 : 0]   rd_ptr;
logic [CNT_W - 1 : 0]   count;
logic                   full;
logic                   push;
logic                   pop;

assign full = ( count == CNT_W'( DEPTH ) );
assign push = wr_i && !full;
assign pop  = video_tvalid_o && video_tready_i;

// Head entry is shown directly, so it holds while tready is low.
assign video_tvalid_o = ( count != '0 );
assign { video_tuser_o, video_tlast_o, video_tdata_o } = mem[rd_ptr];

always_ff @( posedge ref_clk_i )
  if( push )
    mem[wr_ptr] <= { wr_user_i, wr_last_i, wr_data_i };

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end
  else
    begin
      if( push )
        wr_ptr <= ( wr_ptr == PTR_W'( DEPTH - 1 ) ) ? '0 : wr_ptr + 1'b1;
      if( pop )
        rd_ptr <= ( rd_ptr == PTR_W'( DEPTH - 1 ) ) ? '0 : rd_ptr + 1'b1;
      case( { push, pop } )
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Sticky until reset.
      if( wr_i && full )
        overflow_o <= 1'b1;
    end

endmodule

// ==== csi2_rx_top.sv ====
`timescale 1ns/1ps

module csi2_rx_top
  import csi2_pkg::*;
(
  input  logic         ref_clk_i,
  input  logic         ref_srst_i,
  input  logic [1 : 0] btn_i,
  input  lane_byte_t   lane0_raw_i,
  input  lane_byte_t   lane1_raw_i,
  input  logic         lanes_valid_i,
  input  logic         video_tready_i,
  output px_word_t     video_tdata_o,
  output logic         video_tvalid_o,
  output logic         video_tuser_o,
  output logic         video_tlast_o,
  output logic         overflow_o
);

slip_t      slip0;
slip_t      slip1;
logic       lane0_hit;
logic       lane1_hit;
lane_byte_t lane0_byte;
lane_byte_t lane1_byte;
logic       bytes_valid;
logic       pkt_end;
logic       wr;
px_word_t   wr_data;
logic       wr_user;
logic       wr_last;

csi2_delay_ctrl delay_ctrl (
  .ref_clk_i    ( ref_clk_i  ),
  .ref_srst_i   ( ref_srst_i ),
  .btn_i        ( btn_i      ),
  .slip0_o      ( slip0      ),
  .slip1_o      ( slip1      )
);

csi2_lane_aligner lane0_align (
  .ref_clk_i    ( ref_clk_i     ),
  .ref_srst_i   ( ref_srst_i    ),
  .raw_i        ( lane0_raw_i   ),
  .raw_valid_i  ( lanes_valid_i ),
  .slip_i       ( slip0         ),
  .peer_hit_i   ( lane1_hit     ),
  .pkt_end_i    ( pkt_end       ),
  .sync_hit_o   ( lane0_hit     ),
  .byte_o       ( lane0_byte    ),
  .byte_valid_o ( bytes_valid   )
);

// Both lanes lock together, so lane 0's valid qualifies both bytes.
csi2_lane_aligner lane1_align (
  .ref_clk_i    ( ref_clk_i     ),
  .ref_srst_i   ( ref_srst_i    ),
  .raw_i        ( lane1_raw_i   ),
  .raw_valid_i  ( lanes_valid_i ),
  .slip_i       ( slip1         ),
  .peer_hit_i   ( lane0_hit     ),
  .pkt_end_i    ( pkt_end       ),
  .sync_hit_o   ( lane1_hit     ),
  .byte_o       ( lane1_byte    ),
  .byte_valid_o (               )
);

csi2_pkt_parser pkt_parser (
  .ref_clk_i     ( ref_clk_i   ),
  .ref_srst_i    ( ref_srst_i  ),
  .lane0_i       ( lane0_byte  ),
  .lane1_i       ( lane1_byte  ),
  .bytes_valid_i ( bytes_valid ),
  .pkt_end_o     ( pkt_end     ),
  .wr_o          ( wr          ),
  .wr_data_o     ( wr_data     ),
  .wr_user_o     ( wr_user     ),
  .wr_last_o     ( wr_last     )
);

csi2_px_fifo px_fifo (
  .ref_clk_i      ( ref_clk_i      ),
  .ref_srst_i     ( ref_srst_i     ),
  .wr_i           ( wr             ),
  .wr_data_i      ( wr_data        ),
  .wr_user_i      ( wr_user        ),
  .wr_last_i      ( wr_last        ),
  .video_tready_i ( video_tready_i ),
  .video_tdata_o  ( video_tdata_o  ),
  .video_tvalid_o ( video_tvalid_o ),
  .video_tuser_o  ( video_tuser_o  ),
  .video_tlast_o  ( video_tlast_o  ),
  .overflow_o     ( overflow_o     )
);

endmodule

// ==== csi2_rx_assert.sv ====
`timescale 1ns/1ps

module csi2_rx_assert
  import csi2_pkg::*;
(
  input logic     ref_clk_i,
  input logic     ref_srst_i,
  input logic     video_tready_i,
  input px_word_t video_tdata_i,
  input logic     video_tvalid_i,
  input logic     video_tuser_i,
  input logic     video_tlast_i,
  input logic     overflow_i
);

// A stalled word stays on the bus unchanged.
property stall_hold;
  @( posedge ref_clk_i ) disable iff( ref_srst_i )
    video_tvalid_i && !video_tready_i |=>
      video_tvalid_i && $stable( video_tdata_i ) &&
      $stable( video_tuser_i ) && $stable( video_tlast_i );
endproperty

property valid_low_after_reset;
  @( posedge ref_clk_i ) $fell( ref_srst_i ) |-> !video_tvalid_i;
endproperty

property overflow_sticky;
  @( posedge ref_clk_i ) disable iff( ref_srst_i )
    overflow_i |=> overflow_i;
endproperty

stall_hold_a: assert property( stall_hold )
  else $error( "Output word changed or vanished while tready was low." );

valid_low_after_reset_a: assert property( valid_low_after_reset )
  else $error( "tvalid was high right after reset." );

overflow_sticky_a: assert property( overflow_sticky )
  else $error( "overflow fell without a reset." );

endmodule

bind csi2_rx_top csi2_rx_assert rx_assert (
  .ref_clk_i      ( ref_clk_i      ),
  .ref_srst_i     ( ref_srst_i     ),
  .video_tready_i ( video_tready_i ),
  .video_tdata_i  ( video_tdata_o  ),
  .video_tvalid_i ( video_tvalid_o ),
  .video_tuser_i  ( video_tuser_o  ),
  .video_tlast_i  ( video_tlast_o  ),
  .overflow_i     ( overflow_o     )
);

// ==== tb_csi2_rx.sv ====
`timescale 1ns/1ps

`include "csi2_consts.svh"

module tb_csi2_rx
  import csi2_pkg::*;
();

localparam int TIMEOUT_CYCLES = 20000;
localparam int GAP_BYTES      = 4;

logic          ref_clk;
logic          ref_srst;
logic [1 : 0]  btn;
lane_byte_t    lane0_raw;
lane_byte_t    lane1_raw;
logic          lanes_valid;
logic          video_tready = 1'b0;
px_word_t      video_tdata;
logic          video_tvalid;
logic          video_tuser;
logic          video_tlast;
logic          overflow;

lane_byte_t    lane0_q [$];
lane_byte_t    lane1_q [$];
logic [17 : 0] exp_q [$];
logic [17 : 0] exp_word;
logic          tuser_pend;
int            tready_mode = 0;
int            cycle_cnt = 0;

csi2_rx_top dut0 (
  .ref_clk_i      ( ref_clk      ),
  .ref_srst_i     ( ref_srst     ),
  .btn_i          ( btn          ),
  .lane0_raw_i    ( lane0_raw    ),
  .lane1_raw_i    ( lane1_raw    ),
  .lanes_valid_i  ( lanes_valid  ),
  .video_tready_i ( video_tready ),
  .video_tdata_o  ( video_tdata  ),
  .video_tvalid_o ( video_tvalid ),
  .video_tuser_o  ( video_tuser  ),
  .video_tlast_o  ( video_tlast  ),
  .overflow_o     ( overflow     )
);

initial
  begin
    ref_clk = 1'b0;
    forever
      #4 ref_clk = ~ref_clk;
  end

task automatic abort_run( input string msg );
  $display( "%s", msg );
  $display( "sim failed" );
  $fatal( 1 );
endtask

task automatic check_value( input string name, input logic [15 : 0] got,
                            input logic [15 : 0] exp );
  if( got !== exp )
    abort_run( $sformatf( "Error: %s is 0x%0h, expected 0x%0h", name, got, exp ) );
endtask

always @( posedge ref_clk )
  begin
    cycle_cnt <= cycle_cnt + 1;
    if( cycle_cnt >= TIMEOUT_CYCLES )
      abort_run( "Timeout: the output stream did not finish within the cycle limit." );
  end

// Mode 0 keeps the sink ready, mode 1 toggles it at random and any other mode stalls it.
always @( posedge ref_clk )
  case( tready_mode )
    0:       video_tready <= 1'b1;
    1:       video_tready <= 1'( $urandom_range( 1, 0 ) );
    default: video_tready <= 1'b0;
  endcase

always @( posedge ref_clk )
  if( !ref_srst && video_tvalid && video_tready )
    begin
      if( exp_q.size() == 0 )
        abort_run( "An output word arrived when none was expected." );
      else
        begin
          exp_word = exp_q.pop_front();
          check_value( "video_tdata_o", video_tdata, exp_word[15 : 0] );
          check_value( "video_tlast_o", { 15'h0, video_tlast }, { 15'h0, exp_word[16] } );
          check_value( "video_tuser_o", { 15'h0, video_tuser }, { 15'h0, exp_word[17] } );
        end
    end

task automatic apply_reset;
  @( posedge ref_clk );
  ref_srst    <= 1'b1;
  lanes_valid <= 1'b0;
  btn         <= 2'b00;
  repeat( 10 ) @( posedge ref_clk );
  ref_srst    <= 1'b0;
  tuser_pend   = 1'b0;
endtask

task automatic add_pair( input lane_byte_t b0, input lane_byte_t b1 );
  lane0_q.push_back( b0 );
  lane1_q.push_back( b1 );
endtask

task automatic add_gap;
  repeat( GAP_BYTES ) add_pair( 8'h00, 8'h00 );
endtask

task automatic add_short( input data_type_t dt );
  add_pair( `CSI2_SYNC_BYTE, `CSI2_SYNC_BYTE );
  add_pair( { 2'b00, dt }, 8'h00 );
  add_pair( 8'h00, 8'h5A );
  add_gap();
  if( dt == `CSI2_DT_FS )
    tuser_pend = 1'b1;
  else if( dt == `CSI2_DT_FE )
    tuser_pend = 1'b0;
endtask

// Even payload bytes ride on lane 0, odd ones on lane 1.
task automatic add_long( input data_type_t dt, input int nbytes );
  lane_byte_t b0;
  lane_byte_t b1;
  int         i;
  add_pair( `CSI2_SYNC_BYTE, `CSI2_SYNC_BYTE );
  add_pair( { 2'b00, dt }, 8'( nbytes ) );
  add_pair( 8'( nbytes >> 8 ), 8'hC3 );
  for( i = 0; i < nbytes / 2; i++ )
    begin
      b0 = lane_byte_t'( $urandom_range( 255, 0 ) );
      b1 = lane_byte_t'( $urandom_range( 255, 0 ) );
      add_pair( b0, b1 );
      if( dt == `CSI2_DT_RAW8 )
        begin
          exp_q.push_back( { tuser_pend, ( i == nbytes / 2 - 1 ), b1, b0 } );
          tuser_pend = 1'b0;
        end
    end
  add_pair( lane_byte_t'( $urandom_range( 255, 0 ) ), lane_byte_t'( $urandom_range( 255, 0 ) ) );
  add_gap();
endtask

task automatic add_frame( input int nbytes );
  add_gap();
  add_short( `CSI2_DT_FS );
  add_long( `CSI2_DT_RAW8, nbytes );
  add_short( `CSI2_DT_FE );
endtask

// Bits go out LSB first, each lane late by its own number of bits.
task automatic send_lanes( input int delay0, input int delay1 );
  logic       bits0 [$];
  logic       bits1 [$];
  lane_byte_t w0;
  lane_byte_t w1;
  int         nwords;
  int         k;
  int         b;
  nwords = lane0_q.size() + 1;
  repeat( delay0 ) bits0.push_back( 1'b0 );
  repeat( delay1 ) bits1.push_back( 1'b0 );
  for( k = 0; k < lane0_q.size(); k++ )
    for( b = 0; b < 8; b++ )
      begin
        bits0.push_back( lane0_q[k][b] );
        bits1.push_back( lane1_q[k][b] );
      end
  while( bits0.size() < 8 * nwords )
    bits0.push_back( 1'b0 );
  while( bits1.size() < 8 * nwords )
    bits1.push_back( 1'b0 );
  for( k = 0; k < nwords; k++ )
    begin
      for( b = 0; b < 8; b++ )
        begin
          w0[b] = bits0[8 * k + b];
          w1[b] = bits1[8 * k + b];
        end
      @( posedge ref_clk );
      lane0_raw   <= w0;
      lane1_raw   <= w1;
      lanes_valid <= 1'b1;
    end
  @( posedge ref_clk );
  lanes_valid <= 1'b0;
  lane0_q.delete();
  lane1_q.delete();
endtask

task automatic press_buttons( input int n0, input int n1 );
  int i;
  for( i = 0; i < ( ( n0 > n1 ) ? n0 : n1 ); i++ )
    begin
      @( posedge ref_clk );
      btn <= { ( i < n1 ), ( i < n0 ) };
      repeat( 2 ) @( posedge ref_clk );
      btn <= 2'b00;
      repeat( 2 ) @( posedge ref_clk );
    end
endtask

// Idle window after the last expected word, so a stray word still shows up.
task automatic wait_drain;
  while( exp_q.size() != 0 )
    @( negedge ref_clk );
  repeat( 32 ) @( negedge ref_clk );
  check_value( "video_tvalid_o", { 15'h0, video_tvalid }, 16'h0 );
endtask

task automatic test_single_line;
  apply_reset();
  tready_mode <= 0;
  add_frame( 32 );
  send_lanes( 0, 0 );
  wait_drain();
endtask

task automatic test_two_lines;
  apply_reset();
  tready_mode <= 0;
  add_gap();
  add_short( `CSI2_DT_FS );
  add_long( `CSI2_DT_RAW8, 32 );
  add_long( 6'h12, 20 );
  add_long( `CSI2_DT_RAW8, 24 );
  add_short( `CSI2_DT_FE );
  send_lanes( 0, 0 );
  wait_drain();
endtask

task automatic test_bit_slip;
  apply_reset();
  tready_mode <= 0;
  // Slip still at zero, so sync is never found.
  add_frame( 32 );
  exp_q.delete();
  send_lanes( 3, 5 );
  wait_drain();
  press_buttons( 3, 5 );
  add_frame( 32 );
  send_lanes( 3, 5 );
  wait_drain();
endtask

task automatic test_random_ready;
  apply_reset();
  tready_mode <= 1;
  add_frame( 24 );
  send_lanes( 0, 0 );
  wait_drain();
  check_value( "overflow_o", { 15'h0, overflow }, 16'h0 );
  tready_mode <= 0;
endtask

task automatic test_overflow;
  apply_reset();
  tready_mode <= 2;
  add_frame( 64 );
  while( exp_q.size() > `CSI2_FIFO_DEPTH )
    void'( exp_q.pop_back() );
  send_lanes( 0, 0 );
  check_value( "overflow_o", { 15'h0, overflow }, 16'h1 );
  tready_mode <= 0;
  wait_drain();
endtask

initial
  begin
    void'( $urandom( 96472 ) );
    ref_srst    <= 1'b1;
    btn         <= 2'b00;
    lane0_raw   <= 8'h00;
    lane1_raw   <= 8'h00;
    lanes_valid <= 1'b0;
    tuser_pend   = 1'b0;
    test_single_line();
    test_two_lines();
    test_bit_slip();
    test_random_ready();
    test_overflow();
    $display( "sim passed" );
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
csi2_pkg.sv
csi2_delay_ctrl.sv
csi2_lane_aligner.sv
csi2_pkt_parser.sv
csi2_px_fifo.sv
csi2_rx_top.sv
csi2_rx_assert.sv
tb_csi2_rx.sv

// ==== Makefile ====
TOP := tb_csi2_rx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
